//--- project.f
+incdir+.
softmax_data_pkg.sv
softmax_cfg_pkg.sv
softmax_cfg_regs.sv
softmax_max_scan.sv
softmax_exp2_lane.sv
softmax_exp_lanes.sv
softmax_exp_sum.sv
softmax_top.sv
tb_softmax_top.sv

//--- softmax_cfg_pkg.sv
`default_nettype none

package softmax_cfg_pkg;

	// control state codes
	localparam int STATE_W = 32;
	localparam logic [STATE_W-1:0] STATE_MAX_SCAN = 32'd4;
	localparam logic [STATE_W-1:0] STATE_EXP_STREAM = 32'd5;

	// user config word
	localparam int USR_CFG_W = 12;
	localparam int MASK_EN_BIT = 0;
	localparam int VALID_LEN_LSB = 1;
	localparam int VALID_LEN_W = 9;

	// model config word
	localparam int MODEL_CFG_W = 30;
	localparam int SEQ_LEN_LSB = 20;
	localparam int SEQ_LEN_W = 10;

	// global bus address, word index sits in the low bits
	localparam int GBUS_ADDR_W = 19;
	localparam int WORD_IDX_W = 7;

endpackage

`default_nettype wire

//--- softmax_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module softmax_cfg_regs (
	input  logic clk,
	input  logic rst_n,
	input  logic [softmax_cfg_pkg::USR_CFG_W-1:0] usr_cfg,
	input  logic usr_cfg_vld,
	input  logic [softmax_cfg_pkg::MODEL_CFG_W-1:0] model_cfg,
	input  logic model_cfg_vld,
	input  logic [softmax_cfg_pkg::STATE_W-1:0] control_state,
	input  logic control_state_update,
	output logic max_phase,
	output logic exp_phase,
	output logic mask_en,
	output logic [softmax_cfg_pkg::VALID_LEN_W-1:0] valid_len,
	output logic [softmax_cfg_pkg::SEQ_LEN_W-1:0] row_len
);

	logic [softmax_cfg_pkg::USR_CFG_W-1:0] usr_cfg_reg;
	logic [softmax_cfg_pkg::MODEL_CFG_W-1:0] model_cfg_reg;
	logic [softmax_cfg_pkg::STATE_W-1:0] state_reg;
	logic [softmax_cfg_pkg::SEQ_LEN_W-1:0] seq_len;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			usr_cfg_reg <= '0;
			model_cfg_reg <= '0;
			state_reg <= '0;
		end else begin
			if (usr_cfg_vld)
				usr_cfg_reg <= usr_cfg;
			if (model_cfg_vld)
				model_cfg_reg <= model_cfg;
			if (control_state_update)
				state_reg <= control_state;
		end
	end

	assign max_phase = (state_reg == softmax_cfg_pkg::STATE_MAX_SCAN);
	assign exp_phase = (state_reg == softmax_cfg_pkg::STATE_EXP_STREAM);

	assign mask_en = usr_cfg_reg[softmax_cfg_pkg::MASK_EN_BIT];
	assign valid_len = usr_cfg_reg[softmax_cfg_pkg::VALID_LEN_LSB +: softmax_cfg_pkg::VALID_LEN_W];
	assign seq_len = model_cfg_reg[softmax_cfg_pkg::SEQ_LEN_LSB +: softmax_cfg_pkg::SEQ_LEN_W];

	// masked rows end after column valid_len
	assign row_len = mask_en ? (softmax_cfg_pkg::SEQ_LEN_W'(valid_len) + 1'b1) : seq_len;

endmodule

`default_nettype wire

//--- softmax_data_pkg.sv
`default_nettype none

package softmax_data_pkg;

	// stream beat layout
	localparam int LANE_NUM = 16;
	localparam int ELEM_W = 8;

	// element minus row maximum, one extra bit for the sign
	localparam int DIFF_W = ELEM_W + 1;

	// global bus word, four elements per write
	localparam int GBUS_W = 32;
	localparam int GBUS_LANES = GBUS_W / ELEM_W;

	// row sum of exponents
	localparam int SUM_W = 24;

	// 127 * 2^(-j/4) for j = 0..3, index 0 is the lowest field
	localparam logic [3:0][6:0] EXP_MANT = {
		7'd76,
		7'd90,
		7'd107,
		7'd127
	};

	// reset value of the running maximum
	localparam logic signed [ELEM_W-1:0] ELEM_MIN = {1'b1, {(ELEM_W - 1){1'b0}}};

endpackage

`default_nettype wire

//--- softmax_exp2_lane.sv
`timescale 1ns/1ps
`default_nettype none

module softmax_exp2_lane (
	input  logic clk,
	input  logic rst_n,
	input  logic signed [softmax_data_pkg::ELEM_W-1:0] elem,
	input  logic signed [softmax_data_pkg::ELEM_W-1:0] row_max,
	input  logic load,
	output logic [softmax_data_pkg::ELEM_W-1:0] exp_val
);

	logic signed [softmax_data_pkg::DIFF_W-1:0] diff;
	logic [softmax_data_pkg::DIFF_W-1:0] mag;
	logic [softmax_data_pkg::ELEM_W-1:0] exp_nxt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			diff <= '0;
		else if (load)
			diff <= elem - row_max;
	end

	// k = -d, low two bits pick the mantissa, the rest is the shift
	assign mag = -diff;

	always_comb begin
		if (diff > 0)
			exp_nxt = 8'd127;
		else if (mag[softmax_data_pkg::DIFF_W-1:5] != '0)
			exp_nxt = '0;
		else
			exp_nxt = {1'b0, softmax_data_pkg::EXP_MANT[mag[1:0]]} >> mag[4:2];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			exp_val <= '0;
		else
			exp_val <= exp_nxt;
	end

endmodule

`default_nettype wire

//--- softmax_exp_lanes.sv
`timescale 1ns/1ps
`default_nettype none

module softmax_exp_lanes (
	input  logic clk,
	input  logic rst_n,
	input  logic exp_phase,
	input  logic signed [softmax_data_pkg::ELEM_W-1:0] row_max,
	input  logic [softmax_data_pkg::LANE_NUM*softmax_data_pkg::ELEM_W-1:0] in_bus_data,
	input  logic in_bus_data_vld,
	output logic [softmax_data_pkg::LANE_NUM*softmax_data_pkg::ELEM_W-1:0] out_bus_data,
	output logic out_bus_data_vld
);

	logic [softmax_data_pkg::LANE_NUM*softmax_data_pkg::ELEM_W-1:0] in_data_reg;
	logic in_vld_reg;
	logic diff_vld;

	always_ff @(posedge clk) begin
		if (in_bus_data_vld && exp_phase)
			in_data_reg <= in_bus_data;
	end

	// valid follows the two lane stages, one bit per beat in flight
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_vld_reg <= 1'b0;
			diff_vld <= 1'b0;
			out_bus_data_vld <= 1'b0;
		end else begin
			in_vld_reg <= in_bus_data_vld & exp_phase;
			diff_vld <= in_vld_reg;
			out_bus_data_vld <= diff_vld;
		end
	end

	for (genvar i = 0; i < softmax_data_pkg::LANE_NUM; i++) begin : g_lane
		softmax_exp2_lane softmax_exp2_lane_inst (
			.clk     (clk),
			.rst_n   (rst_n),
			.elem    (in_data_reg[i * softmax_data_pkg::ELEM_W +: softmax_data_pkg::ELEM_W]),
			.row_max (row_max),
			.load    (in_vld_reg),
			.exp_val (out_bus_data[i * softmax_data_pkg::ELEM_W +: softmax_data_pkg::ELEM_W])
		);
	end

endmodule

`default_nettype wire

//--- softmax_exp_sum.sv
`timescale 1ns/1ps
`default_nettype none

module softmax_exp_sum (
	input  logic clk,
	input  logic rst_n,
	input  logic clear,
	input  logic [softmax_cfg_pkg::SEQ_LEN_W-1:0] row_len,
	input  logic [softmax_data_pkg::LANE_NUM*softmax_data_pkg::ELEM_W-1:0] out_bus_data,
	input  logic out_bus_data_vld,
	output logic [softmax_data_pkg::SUM_W-1:0] exp_sum,
	output logic exp_sum_vld
);

	logic [softmax_cfg_pkg::SEQ_LEN_W-1:0] elem_cnt;
	logic [softmax_cfg_pkg::SEQ_LEN_W-1:0] cnt_nxt;
	logic done;
	logic last_hit;
	logic [softmax_data_pkg::SUM_W-1:0] acc;
	logic [softmax_data_pkg::SUM_W-1:0] beat_sum;
	logic beat_take;

	assign beat_take = out_bus_data_vld & ~done;

	// lanes in order, nothing past the last lane is counted or summed
	always_comb begin
		cnt_nxt = elem_cnt;
		beat_sum = '0;
		last_hit = 1'b0;
		for (int i = 0; i < softmax_data_pkg::LANE_NUM; i++) begin
			if (!last_hit) begin
				cnt_nxt = cnt_nxt + 1'b1;
				beat_sum = beat_sum + softmax_data_pkg::SUM_W'(
					out_bus_data[i * softmax_data_pkg::ELEM_W +: softmax_data_pkg::ELEM_W]);
				if (cnt_nxt == row_len)
					last_hit = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			elem_cnt <= '0;
			done <= 1'b0;
			acc <= '0;
			exp_sum <= '0;
			exp_sum_vld <= 1'b0;
		end else if (clear) begin
			elem_cnt <= '0;
			done <= 1'b0;
			acc <= '0;
			exp_sum_vld <= 1'b0;
		end else begin
			exp_sum_vld <= beat_take & last_hit;
			if (beat_take) begin
				elem_cnt <= cnt_nxt;
				acc <= acc + beat_sum;
				done <= last_hit;
				// total includes the beat holding the last lane
				if (last_hit)
					exp_sum <= acc + beat_sum;
			end
		end
	end

endmodule

`default_nettype wire

//--- softmax_max_scan.sv
`timescale 1ns/1ps
`default_nettype none

module softmax_max_scan (
	input  logic clk,
	input  logic rst_n,
	input  logic clear,
	input  logic max_phase,
	input  logic mask_en,
	input  logic [softmax_cfg_pkg::VALID_LEN_W-1:0] valid_len,
	input  logic gbus_wen,
	input  logic [softmax_data_pkg::GBUS_W-1:0] gbus_wdata,
	input  logic [softmax_cfg_pkg::GBUS_ADDR_W-1:0] gbus_addr,
	output logic signed [softmax_data_pkg::ELEM_W-1:0] row_max
);

	logic wr_vld;
	logic [softmax_data_pkg::GBUS_W-1:0] wr_data;
	logic [softmax_cfg_pkg::WORD_IDX_W-1:0] wr_idx;
	logic signed [softmax_data_pkg::ELEM_W-1:0] max_nxt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wr_vld <= 1'b0;
		else
			wr_vld <= gbus_wen & max_phase;
	end

	always_ff @(posedge clk) begin
		if (gbus_wen && max_phase) begin
			wr_data <= gbus_wdata;
			wr_idx <= gbus_addr[softmax_cfg_pkg::WORD_IDX_W-1:0];
		end
	end

	// fold the four elements of the word, skipping masked columns
	always_comb begin
		logic signed [softmax_data_pkg::ELEM_W-1:0] elem;
		logic [softmax_cfg_pkg::WORD_IDX_W+1:0] col;
		max_nxt = row_max;
		for (int i = 0; i < softmax_data_pkg::GBUS_LANES; i++) begin
			elem = wr_data[i * softmax_data_pkg::ELEM_W +: softmax_data_pkg::ELEM_W];
			col = {wr_idx, i[1:0]};
			if ((!mask_en || col <= valid_len) && elem > max_nxt)
				max_nxt = elem;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			row_max <= softmax_data_pkg::ELEM_MIN;
		else if (clear)
			row_max <= softmax_data_pkg::ELEM_MIN;
		else if (wr_vld)
			row_max <= max_nxt;
	end

endmodule

`default_nettype wire

//--- softmax_top.sv
`timescale 1ns/1ps
`default_nettype none

module softmax_top (
	input  logic clk,
	input  logic rst_n,
	input  logic [11:0] usr_cfg,
	input  logic usr_cfg_vld,
	input  logic [29:0] model_cfg,
	input  logic model_cfg_vld,
	input  logic [31:0] control_state,
	input  logic control_state_update,
	input  logic gbus_wen,
	input  logic [31:0] gbus_wdata,
	input  logic [18:0] gbus_addr,
	input  logic [127:0] in_bus_data,
	input  logic in_bus_data_vld,
	input  logic clear,
	output logic [127:0] out_bus_data,
	output logic out_bus_data_vld,
	output logic [23:0] exp_sum,
	output logic exp_sum_vld
);

	logic max_phase;
	logic exp_phase;
	logic mask_en;
	logic [8:0] valid_len;
	logic [9:0] row_len;
	logic signed [7:0] row_max;

	softmax_cfg_regs softmax_cfg_regs_inst (
		.clk                  (clk),
		.rst_n                (rst_n),
		.usr_cfg              (usr_cfg),
		.usr_cfg_vld          (usr_cfg_vld),
		.model_cfg            (model_cfg),
		.model_cfg_vld        (model_cfg_vld),
		.control_state        (control_state),
		.control_state_update (control_state_update),
		.max_phase            (max_phase),
		.exp_phase            (exp_phase),
		.mask_en              (mask_en),
		.valid_len            (valid_len),
		.row_len              (row_len)
	);

	softmax_max_scan softmax_max_scan_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.clear      (clear),
		.max_phase  (max_phase),
		.mask_en    (mask_en),
		.valid_len  (valid_len),
		.gbus_wen   (gbus_wen),
		.gbus_wdata (gbus_wdata),
		.gbus_addr  (gbus_addr),
		.row_max    (row_max)
	);

	softmax_exp_lanes softmax_exp_lanes_inst (
		.clk              (clk),
		.rst_n            (rst_n),
		.exp_phase        (exp_phase),
		.row_max          (row_max),
		.in_bus_data      (in_bus_data),
		.in_bus_data_vld  (in_bus_data_vld),
		.out_bus_data     (out_bus_data),
		.out_bus_data_vld (out_bus_data_vld)
	);

	softmax_exp_sum softmax_exp_sum_inst (
		.clk              (clk),
		.rst_n            (rst_n),
		.clear            (clear),
		.row_len          (row_len),
		.out_bus_data     (out_bus_data),
		.out_bus_data_vld (out_bus_data_vld),
		.exp_sum          (exp_sum),
		.exp_sum_vld      (exp_sum_vld)
	);

endmodule

`default_nettype wire

//--- tb_softmax_tasks.svh
	task automatic step();
		@(posedge clk);
		#5;
	endtask

	// config words and state captured on one edge
	task automatic setup(input logic [11:0] usr, input logic [29:0] model,
			input logic [31:0] state, input logic clr);
		{usr_cfg, model_cfg, control_state, clear} = {usr, model, state, clr};
		{usr_cfg_vld, model_cfg_vld, control_state_update} = 3'b111;
		step();
		{usr_cfg_vld, model_cfg_vld, control_state_update, clear} = 4'b0;
	endtask

	task automatic bus_write(input int idx, input logic [31:0] data);
		gbus_wen = 1'b1;
		gbus_addr = 19'(idx);
		gbus_wdata = data;
		step();
		gbus_wen = 1'b0;
	endtask

	task automatic send_beat(input logic [127:0] data);
		in_bus_data = data;
		in_bus_data_vld = 1'b1;
		step();
		in_bus_data_vld = 1'b0;
	endtask

	// cycles from the last drive until the chosen valid rises
	task automatic wait_valid(input logic sum_sel, output int cyc);
		cyc = 1;
		while (!(sum_sel ? exp_sum_vld : out_bus_data_vld) && cyc < 20) begin
			step();
			cyc++;
		end
		if (!(sum_sel ? exp_sum_vld : out_bus_data_vld)) begin
			$display("timeout: %s never rose", sum_sel ? "exp_sum_vld" : "out_bus_data_vld");
			errors++;
		end
	endtask

	task automatic check_beat(input logic [127:0] data, input logic signed [7:0] mx);
		int cyc;
		int exp_v;
		send_beat(data);
		wait_valid(1'b0, cyc);
		checks++;
		if (cyc != 3) begin
			$display("Fail t=%0t out_bus_data_vld latency: got %0d expected 3", $time, cyc);
			errors++;
		end
		for (int i = 0; i < 16; i++) begin
			exp_v = exp_ref(data[i*8 +: 8], mx);
			checks++;
			if (out_bus_data[i*8 +: 8] != exp_v) begin
				$display("Fail t=%0t out_bus_data[%0d]: got %0d expected %0d",
					$time, i, out_bus_data[i*8 +: 8], exp_v);
				errors++;
			end
		end
	endtask

	// beats back to back and one sum pulse after the last output beat
	task automatic check_row(input int n_beats, input int len, input logic signed [7:0] mx);
		int cyc;
		int exp_s;
		for (int b = 0; b < n_beats; b++)
			send_beat(row_beats[b]);
		wait_valid(1'b1, cyc);
		exp_s = row_sum(len, mx);
		checks += 2;
		if (cyc != 4) begin
			$display("Fail t=%0t exp_sum_vld latency: got %0d expected 4", $time, cyc);
			errors++;
		end
		if (exp_sum != exp_s) begin
			$display("Fail t=%0t exp_sum: got %0d expected %0d", $time, exp_sum, exp_s);
			errors++;
		end
		step();
		checks++;
		if (exp_sum_vld) begin
			$display("Fail t=%0t exp_sum_vld: got %b expected 0", $time, exp_sum_vld);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err0);
		$display("%s finished with %0d errors", name, errors - err0);
	endtask

	task automatic test_reset();
		int err0;
		err0 = errors;
		repeat (3) begin
			checks++;
			if (out_bus_data_vld || exp_sum_vld) begin
				$display("Fail t=%0t out_bus_data_vld/exp_sum_vld: got %b/%b expected 0/0",
					$time, out_bus_data_vld, exp_sum_vld);
				errors++;
			end
			step();
		end
		// d is zero against the reset maximum without a scan
		setup(12'd0, 30'd0, 32'd5, 1'b0);
		check_beat({16{8'h80}}, 8'sh80);
		report_test("reset state", err0);
	endtask

	task automatic test_unmasked_max();
		int err0;
		logic [31:0] w;
		logic signed [7:0] mx;
		err0 = errors;
		setup(12'd0, 30'd0, 32'd4, 1'b1);
		mx = 8'sh80;
		for (int i = 0; i < 4; i++) begin
			w = $random(seed);
			mx = fold_max(mx, w, i, 1'b0, 0);
			bus_write(i, w);
		end
		setup(12'd0, 30'd0, 32'd5, 1'b0);
		repeat (2)
			check_beat({$random(seed), $random(seed), $random(seed), $random(seed)}, mx);
		report_test("unmasked maximum", err0);
	endtask

	task automatic test_masked_max();
		int err0;
		logic signed [7:0] mx;
		err0 = errors;
		// the 100 in column 6 lies past valid_len 5
		setup({2'b0, 9'd5, 1'b1}, 30'd0, 32'd4, 1'b1);
		bus_write(0, 32'hf90ce207);
		bus_write(1, 32'h056414fb);
		mx = fold_max(8'sh80, 32'hf90ce207, 0, 1'b1, 5);
		mx = fold_max(mx, 32'h056414fb, 1, 1'b1, 5);
		setup({2'b0, 9'd5, 1'b1}, 30'd0, 32'd5, 1'b0);
		// lane i sits i below the kept maximum
		check_beat(128'h05060708090a0b0c0d0e0f1011121314, mx);
		report_test("masked maximum", err0);
	endtask

	task automatic test_state_gating();
		int err0;
		err0 = errors;
		setup(12'd0, 30'd0, 32'd6, 1'b1);
		bus_write(0, 32'h7f7f7f7f);
		send_beat({16{8'h55}});
		repeat (5) begin
			checks++;
			if (out_bus_data_vld) begin
				$display("Fail t=%0t out_bus_data_vld: got 1 expected 0", $time);
				errors++;
			end
			step();
		end
		// maximum must still be the cleared value
		setup(12'd0, 30'd0, 32'd5, 1'b0);
		check_beat({16{8'h80}}, 8'sh80);
		report_test("state gating", err0);
	endtask

	task automatic test_row_sum();
		int err0;
		logic [31:0] w;
		err0 = errors;
		setup(12'd0, {10'd40, 20'd0}, 32'd4, 1'b1);
		w = $random(seed);
		bus_write(0, w);
		setup(12'd0, {10'd40, 20'd0}, 32'd5, 1'b0);
		for (int b = 0; b < 3; b++)
			row_beats[b] = {$random(seed), $random(seed), $random(seed), $random(seed)};
		check_row(3, 40, fold_max(8'sh80, w, 0, 1'b0, 0));
		report_test("row sum", err0);
	endtask

	task automatic test_clear();
		int err0;
		err0 = errors;
		// valid_len 9 gives a ten element row
		setup({2'b0, 9'd9, 1'b1}, {10'd40, 20'd0}, 32'd4, 1'b1);
		bus_write(0, 32'hd8cec4ba);
		setup({2'b0, 9'd9, 1'b1}, {10'd40, 20'd0}, 32'd5, 1'b0);
		row_beats[0] = {$random(seed), $random(seed), $random(seed), $random(seed)};
		check_row(1, 10, fold_max(8'sh80, 32'hd8cec4ba, 0, 1'b1, 9));
		report_test("clear", err0);
	endtask

//--- tb_softmax_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_softmax_top;

	logic clk;
	logic rst_n;
	logic [11:0] usr_cfg;
	logic usr_cfg_vld;
	logic [29:0] model_cfg;
	logic model_cfg_vld;
	logic [31:0] control_state;
	logic control_state_update;
	logic gbus_wen;
	logic [31:0] gbus_wdata;
	logic [18:0] gbus_addr;
	logic [127:0] in_bus_data;
	logic in_bus_data_vld;
	logic clear;
	logic [127:0] out_bus_data;
	logic out_bus_data_vld;
	logic [23:0] exp_sum;
	logic exp_sum_vld;

	integer seed;
	integer errors;
	integer checks;
	logic [127:0] row_beats [0:2];

	softmax_top softmax_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// base-2 exponent of one element against the row maximum
	function automatic int exp_ref(input logic signed [7:0] elem, input logic signed [7:0] mx);
		int k;
		int mant;
		k = mx - elem;
		if (k < 0)
			return 127;
		case (k % 4)
			0: mant = 127;
			1: mant = 107;
			2: mant = 90;
			default: mant = 76;
		endcase
		if (k / 4 >= 8)
			return 0;
		return mant >> (k / 4);
	endfunction

	// one bus word folded into the maximum, masked columns skipped
	function automatic logic signed [7:0] fold_max(input logic signed [7:0] cur,
			input logic [31:0] word, input int idx, input logic mask, input int vlen);
		logic signed [7:0] e;
		for (int i = 0; i < 4; i++) begin
			e = word[i*8 +: 8];
			if ((!mask || idx * 4 + i <= vlen) && e > cur)
				cur = e;
		end
		return cur;
	endfunction

	// first len lanes of the stored beats, lane 0 first
	function automatic int row_sum(input int len, input logic signed [7:0] mx);
		int s;
		s = 0;
		for (int n = 0; n < len; n++)
			s += exp_ref(row_beats[n / 16][(n % 16) * 8 +: 8], mx);
		return s;
	endfunction

	`include "tb_softmax_tasks.svh"

	initial begin
		seed = 32'hc566b6e8;
		errors = 0;
		checks = 0;
		rst_n = 1'b0;
		{usr_cfg, usr_cfg_vld, model_cfg, model_cfg_vld, control_state, control_state_update,
			gbus_wen, gbus_wdata, gbus_addr, in_bus_data, in_bus_data_vld, clear} = '0;
		repeat (3) @(posedge clk);
		#5;
		rst_n = 1'b1;
		test_reset();
		test_unmasked_max();
		test_masked_max();
		test_state_gating();
		test_row_sum();
		test_clear();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire
